// ==== verilog/ble_reading_pkg.sv ====
/* Shared constants, vector types and the digit frame of the BLE reading path.
   Each module pulls these in by a wildcard import in its header. */

package ble_reading_pkg;

   // ************************************************************************
   // Serial line timing
   // ************************************************************************

   // 16x oversampling tick from the system clock
   localparam int BAUD_DIVISOR = 27;
   localparam int OVERSAMPLE   = 16;
   localparam int DATA_BITS    = 8;

   localparam int BAUD_CNT_W = $clog2(BAUD_DIVISOR);
   localparam int TICK_CNT_W = $clog2(OVERSAMPLE);
   localparam int BIT_CNT_W  = $clog2(DATA_BITS);

   // ************************************************************************
   // Text format
   // ************************************************************************

   localparam int NUM_DIGITS = 8;

   // Counts 0..NUM_DIGITS plus one "too many" value
   localparam int DIGIT_CNT_W = $clog2(NUM_DIGITS + 2);

   typedef logic [DATA_BITS-1:0]      ascii_t;
   typedef logic [3:0]                nibble_t;
   typedef logic [NUM_DIGITS*4-1:0]   reading_t;

   localparam ascii_t ASCII_LF = 8'd10;

   // First received digit sits in chars[NUM_DIGITS-1]
   typedef struct packed {
      ascii_t [NUM_DIGITS-1:0] chars;
   } digit_frame_t;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

endpackage

// ==== verilog/uart_byte_rx.sv ====
/* 8N1 UART receiver with its own 16x oversampling tick counter.
   Strobes o_byte_valid for one cycle per received character. */
`timescale 1ns/10ps

module uart_byte_rx
   import ble_reading_pkg::*;
(
   input  logic   clk,
   input  logic   i_rst,
   input  logic   i_rx,
   output ascii_t o_byte,
   output logic   o_byte_valid
);

   logic [BAUD_CNT_W-1:0] baud_cnt;
   logic                  baud_tick;
   logic [1:0]            rx_sync;
   logic                  rx_bit;
   rx_state_t             state;
   logic [TICK_CNT_W-1:0] tick_cnt;
   logic [BIT_CNT_W-1:0]  bit_cnt;
   ascii_t                rx_shift;

   // ************************************************************************
   // Oversampling tick
   // ************************************************************************

   // Free running, one tick every BAUD_DIVISOR clocks
   always_ff @(posedge clk) begin
      if (i_rst) begin
         baud_cnt <= '0;
      end else if (baud_tick) begin
         baud_cnt <= '0;
      end else begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

   assign baud_tick = (baud_cnt == BAUD_CNT_W'(BAUD_DIVISOR - 1));

   // Line comes from another clock domain
   always_ff @(posedge clk) begin
      if (i_rst) begin
         rx_sync <= 2'b11;
      end else begin
         rx_sync <= {rx_sync[0], i_rx};
      end
   end

   assign rx_bit = rx_sync[1];

   // ************************************************************************
   // Receive state machine
   // ************************************************************************

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state        <= RX_IDLE;
         tick_cnt     <= '0;
         bit_cnt      <= '0;
         o_byte_valid <= 1'b0;
      end else begin
         o_byte_valid <= 1'b0;
         case (state)
            RX_IDLE: begin
               // Idle line is high, a low level is the start edge
               if (!rx_bit) begin
                  state    <= RX_START;
                  tick_cnt <= '0;
               end
            end
            RX_START: begin
               if (baud_tick) begin
                  if (tick_cnt == TICK_CNT_W'(OVERSAMPLE / 2 - 1)) begin
                     tick_cnt <= '0;
                     bit_cnt  <= '0;
                     // Glitch shorter than half a bit goes back to idle
                     state    <= rx_bit ? RX_IDLE : RX_DATA;
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end
            RX_DATA: begin
               if (baud_tick) begin
                  if (tick_cnt == TICK_CNT_W'(OVERSAMPLE - 1)) begin
                     tick_cnt <= '0;
                     if (bit_cnt == BIT_CNT_W'(DATA_BITS - 1)) begin
                        state <= RX_STOP;
                     end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                     end
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end
            RX_STOP: begin
               // Middle of stop bit, level is not checked
               if (baud_tick) begin
                  if (tick_cnt == TICK_CNT_W'(OVERSAMPLE - 1)) begin
                     tick_cnt     <= '0;
                     state        <= RX_IDLE;
                     o_byte_valid <= 1'b1;
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end
            default: begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

   // Data bits arrive LSB first
   always_ff @(posedge clk) begin
      if (state == RX_DATA && baud_tick && tick_cnt == TICK_CNT_W'(OVERSAMPLE - 1)) begin
         rx_shift <= {rx_bit, rx_shift[DATA_BITS-1:1]};
      end
   end

   assign o_byte = rx_shift;

endmodule

// ==== verilog/hex_line_parser.sv ====
/* Collects lines of exactly eight hex digits ended by LF into a digit frame.
   The frame waits in a one-entry buffer for the decoder lanes. */
`timescale 1ns/10ps

module hex_line_parser
   import ble_reading_pkg::*;
(
   input  logic         clk,
   input  logic         i_rst,
   input  ascii_t       i_byte,
   input  logic         i_byte_valid,
   input  logic         i_frame_ready,
   output digit_frame_t o_frame,
   output logic         o_frame_valid,
   output logic         o_overrun
);

   logic [DIGIT_CNT_W-1:0] digit_cnt;
   digit_frame_t           line_buf;
   logic                   is_hex;
   logic                   frame_done;
   logic                   buf_free;

   always_comb begin
      is_hex = ((i_byte >= "0") && (i_byte <= "9")) ||
               ((i_byte >= "a") && (i_byte <= "f")) ||
               ((i_byte >= "A") && (i_byte <= "F"));
   end

   assign frame_done = i_byte_valid && (i_byte == ASCII_LF) &&
                       (digit_cnt == DIGIT_CNT_W'(NUM_DIGITS));

   // Buffer can take a frame if empty or drained this cycle
   assign buf_free = !o_frame_valid || i_frame_ready;

   // ************************************************************************
   // Line collection
   // ************************************************************************

   // Count sticks at NUM_DIGITS+1 once the line is too long
   always_ff @(posedge clk) begin
      if (i_rst) begin
         digit_cnt <= '0;
      end else if (i_byte_valid) begin
         if (is_hex) begin
            if (digit_cnt != DIGIT_CNT_W'(NUM_DIGITS + 1)) begin
               digit_cnt <= digit_cnt + 1'b1;
            end
         end else begin
            // LF or any other character starts a new line
            digit_cnt <= '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_byte_valid && is_hex) begin
         line_buf.chars <= {line_buf.chars[NUM_DIGITS-2:0], i_byte};
      end
   end

   // ************************************************************************
   // Output buffer
   // ************************************************************************

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_frame_valid <= 1'b0;
         o_overrun     <= 1'b0;
      end else begin
         o_overrun <= 1'b0;
         if (o_frame_valid && i_frame_ready) begin
            o_frame_valid <= 1'b0;
         end
         if (frame_done) begin
            if (buf_free) begin
               o_frame_valid <= 1'b1;
            end else begin
               // UART cannot stall, new frame is lost
               o_overrun <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (frame_done && buf_free) begin
         o_frame <= line_buf;
      end
   end

endmodule

// ==== verilog/hex_digit_decoder.sv ====
/* One decoder lane: registers the nibble value of an ASCII hex digit.
   Advances only when the downstream register is ready. */
`timescale 1ns/10ps

module hex_digit_decoder
   import ble_reading_pkg::*;
(
   input  logic    clk,
   input  logic    i_rst,
   input  ascii_t  i_char,
   input  logic    i_valid,
   input  logic    i_ready,
   output nibble_t o_nibble,
   output logic    o_valid
);

   nibble_t nibble_d;

   // Letters of both cases have bit 6 set and low nibble 1..6
   always_comb begin
      nibble_d = i_char[3:0] + (i_char[6] ? 4'd9 : 4'd0);
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_valid <= 1'b0;
      end else if (i_ready) begin
         o_valid <= i_valid;
      end
   end

   // Held while the reading register is busy
   always_ff @(posedge clk) begin
      if (i_ready && i_valid) begin
         o_nibble <= nibble_d;
      end
   end

endmodule

// ==== verilog/reading_register.sv ====
/* Packs the eight lane nibbles into one reading and offers it on valid/ready.
   Lane 0 carries the most significant digit. */
`timescale 1ns/10ps

module reading_register
   import ble_reading_pkg::*;
(
   input  logic                     clk,
   input  logic                     i_rst,
   input  nibble_t [NUM_DIGITS-1:0] i_nibbles,
   input  logic                     i_valid,
   input  logic                     i_ready,
   output logic                     o_lane_ready,
   output reading_t                 o_reading,
   output logic                     o_valid
);

   reading_t packed_reading;

   always_comb begin
      for (int k = 0; k < NUM_DIGITS; k++) begin
         packed_reading[4*(NUM_DIGITS-1-k) +: 4] = i_nibbles[k];
      end
   end

   // Empty, or the current reading leaves this cycle
   assign o_lane_ready = !o_valid || i_ready;

   // All lanes move together so lane 0 valid stands for the set
   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_valid   <= 1'b0;
         o_reading <= '0;
      end else if (o_lane_ready) begin
         o_valid <= i_valid;
         if (i_valid) begin
            o_reading <= packed_reading;
         end
      end
   end

endmodule

// ==== verilog/ble_reading_top.sv ====
/* BLE accelerometer reading path: UART receiver, hex line parser,
   eight decoder lanes and the output reading register. */
`timescale 1ns/10ps

module ble_reading_top
   import ble_reading_pkg::*;
(
   input  logic     clk,
   input  logic     i_rst,
   input  logic     i_rx,
   input  logic     i_ready,
   output reading_t o_reading,
   output logic     o_valid,
   output logic     o_overrun
);

   ascii_t                   rx_byte;
   logic                     rx_byte_valid;
   digit_frame_t             frame;
   logic                     frame_valid;
   logic                     lane_ready;
   nibble_t [NUM_DIGITS-1:0] lane_nibbles;
   logic [NUM_DIGITS-1:0]    lane_valid;

   uart_byte_rx u_rx (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_rx         (i_rx),
      .o_byte       (rx_byte),
      .o_byte_valid (rx_byte_valid)
   );

   // Lanes take a frame whenever the reading register can take theirs
   hex_line_parser u_parser (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_byte        (rx_byte),
      .i_byte_valid  (rx_byte_valid),
      .i_frame_ready (lane_ready),
      .o_frame       (frame),
      .o_frame_valid (frame_valid),
      .o_overrun     (o_overrun)
   );

   // Lane k decodes the k-th received digit
   for (genvar k = 0; k < NUM_DIGITS; k++) begin : g_lane
      hex_digit_decoder u_lane (
         .clk      (clk),
         .i_rst    (i_rst),
         .i_char   (frame.chars[NUM_DIGITS-1-k]),
         .i_valid  (frame_valid),
         .i_ready  (lane_ready),
         .o_nibble (lane_nibbles[k]),
         .o_valid  (lane_valid[k])
      );
   end

   reading_register u_reading (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_nibbles    (lane_nibbles),
      .i_valid      (lane_valid[0]),
      .i_ready      (i_ready),
      .o_lane_ready (lane_ready),
      .o_reading    (o_reading),
      .o_valid      (o_valid)
   );

endmodule

// ==== verification/ble_reading_checker.sv ====
/* Concurrent assertions on the output handshake of the reading path.
   Bound into the top level by the testbench. */
`timescale 1ns/10ps

module ble_reading_checker
   import ble_reading_pkg::*;
(
   input logic     clk,
   input logic     i_rst,
   input logic     i_ready,
   input reading_t i_reading,
   input logic     i_valid,
   input logic     i_overrun
);

   // A reading offered without ready stays offered
   a_valid_held: assert property (@(posedge clk) disable iff (i_rst)
      i_valid && !i_ready |=> i_valid)
      else $error("o_valid dropped while the consumer was stalling");

   // ...and its value does not move
   a_reading_stable: assert property (@(posedge clk) disable iff (i_rst)
      i_valid && !i_ready |=> $stable(i_reading))
      else $error("o_reading changed while the consumer was stalling");

   // Overrun is a single cycle pulse
   a_overrun_pulse: assert property (@(posedge clk) disable iff (i_rst)
      i_overrun |=> !i_overrun)
      else $error("o_overrun stayed high for two cycles");

   a_outputs_known: assert property (@(posedge clk) disable iff (i_rst)
      !$isunknown({i_valid, i_overrun, i_reading}))
      else $error("An output of the reading path is unknown");

endmodule

// ==== include/tb_uart_tasks.svh ====
/* Testbench tasks that build random text lines and serialize them as 8N1.
   Included inside the testbench module, they drive its rx signal on clk. */
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

function automatic ascii_t hex_char(input nibble_t v, input bit upper);
   if (v < 4'd10) begin
      return ascii_t'("0") + ascii_t'(v);
   end
   return (upper ? ascii_t'("A") : ascii_t'("a")) + ascii_t'(v - 4'd10);
endfunction

// Line kinds are 0 good, 1 seven digits, 2 nine digits, 3 non-hex, 4 no LF
task automatic build_line(input int kind, output ascii_t line[$],
                          output bit good, output reading_t value);
   int       ndig;
   int       pos;
   reading_t v;
   v     = $urandom;
   value = v;
   good  = (kind == 0);
   ndig  = (kind == 1) ? 7 : (kind == 2) ? 9 : 8;
   line  = {};
   // Leading CR flushes a line left open by the previous one
   line.push_back(8'd13);
   for (int i = 0; i < ndig; i++) begin
      line.push_back(hex_char(v[31 - 4 * (i % 8) -: 4], 1'($urandom_range(0, 1))));
   end
   if (kind == 3) begin
      pos       = $urandom_range(1, ndig);
      line[pos] = 8'h67 + 8'($urandom_range(0, 10));
   end
   if (kind != 4) begin
      line.push_back(ASCII_LF);
   end
endtask

// Start bit, eight data bits LSB first, stop bit
task automatic uart_send_byte(input ascii_t b);
   logic [9:0] bits;
   bits = {1'b1, b, 1'b0};
   for (int i = 0; i < 10; i++) begin
      rx = bits[i];
      repeat (BAUD_DIVISOR * OVERSAMPLE) @(negedge clk);
   end
endtask

task automatic uart_send_line(input ascii_t line[$]);
   foreach (line[i]) begin
      uart_send_byte(line[i]);
   end
   repeat ($urandom_range(0, 2000)) @(negedge clk);
endtask

`endif

// ==== verification/ble_reading_tb.sv ====
/* Testbench for the BLE reading path: random text lines over the UART,
   a queue of expected readings and a stalling consumer on the output. */
`timescale 1ns/10ps

module ble_reading_tb
   import ble_reading_pkg::*;
();

   localparam int SEED       = 61434;
   localparam int NUM_LINES  = 40;
   localparam int BIT_CYCLES = BAUD_DIVISOR * OVERSAMPLE;
   // 12 characters of 10 bits per line, plus a quarter
   localparam int TIMEOUT_CYCLES = NUM_LINES * 12 * 10 * BIT_CYCLES * 5 / 4;

   logic     clk;
   logic     i_rst;
   logic     rx;
   logic     i_ready;
   reading_t o_reading;
   logic     o_valid;
   logic     o_overrun;

   reading_t exp_q[$];
   int       errors;
   int       overruns;
   int       received;
   int       good_lines;
   int       cycles;
   bit       all_sent;
   bit       first_good;
   bit       stalled_prev;
   reading_t held_reading;

   `include "tb_uart_tasks.svh"

   ble_reading_top DUT (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_rx      (rx),
      .i_ready   (i_ready),
      .o_reading (o_reading),
      .o_valid   (o_valid),
      .o_overrun (o_overrun)
   );

   bind ble_reading_top ble_reading_checker u_checker (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_ready   (i_ready),
      .i_reading (o_reading),
      .i_valid   (o_valid),
      .i_overrun (o_overrun)
   );

   always #4 clk = ~clk;

   // ************************************************************************
   // Scoreboard, sampled at the rising edge
   // ************************************************************************

   always @(posedge clk) begin : scoreboard
      reading_t expected;
      if (!i_rst) begin
         if (!first_good && (o_valid || o_overrun)) begin
            errors++;
            $display("Output became active at %0t before any good line was sent", $time);
         end
         if (stalled_prev && (!o_valid || o_reading !== held_reading)) begin
            errors++;
            $display("Fail at %0t: stalled reading %h changed to %h (valid %b)",
                     $time, held_reading, o_reading, o_valid);
         end
         if (o_valid && i_ready) begin
            received++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("Reading %h at %0t came with no good line outstanding",
                        o_reading, $time);
            end else begin
               expected = exp_q.pop_front();
               if (o_reading !== expected) begin
                  errors++;
                  $display("Fail at %0t: expected reading %h, got %h",
                           $time, expected, o_reading);
               end
            end
         end
         // The dropped frame is always the newest good line
         if (o_overrun) begin
            overruns++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("Overrun at %0t with no good line outstanding", $time);
            end else begin
               void'(exp_q.pop_back());
            end
         end
      end
      stalled_prev = !i_rst && o_valid && !i_ready;
      held_reading = o_reading;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Run timed out after %0d cycles with %0d readings still expected",
                  cycles, exp_q.size());
         $display("** FAIL **");
         $finish;
      end
   end

   // ************************************************************************
   // Consumer with long random stalls
   // ************************************************************************

   initial begin : consumer
      int stall;
      int open;
      @(negedge clk);
      while (i_rst) @(negedge clk);
      while (!all_sent) begin
         stall   = $urandom_range(0, 300000);
         i_ready = 1'b0;
         for (int c = 0; c < stall && !all_sent; c++) @(negedge clk);
         open    = $urandom_range(1, 20000);
         i_ready = 1'b1;
         for (int c = 0; c < open && !all_sent; c++) @(negedge clk);
      end
      i_ready = 1'b1;
   end

   // ************************************************************************
   // Stimulus and verdict
   // ************************************************************************

   initial begin : stimulus
      ascii_t   line[$];
      bit       good;
      reading_t value;
      int       kind;
      void'($urandom(SEED));
      errors       = 0;
      overruns     = 0;
      received     = 0;
      good_lines   = 0;
      cycles       = 0;
      all_sent     = 1'b0;
      first_good   = 1'b0;
      stalled_prev = 1'b0;
      clk          = 1'b0;
      i_rst        = 1'b1;
      rx           = 1'b1;
      i_ready      = 1'b0;
      repeat (4) @(negedge clk);
      i_rst = 1'b0;

      for (int n = 0; n < NUM_LINES; n++) begin
         // Half good lines, the rest spread over the bad kinds
         kind = ($urandom_range(0, 1) == 0) ? 0 : int'($urandom_range(1, 4));
         build_line(kind, line, good, value);
         if (good) begin
            exp_q.push_back(value);
            good_lines++;
            first_good = 1'b1;
         end
         uart_send_line(line);
      end
      all_sent = 1'b1;

      while (exp_q.size() != 0) @(negedge clk);
      // Room for a stray extra reading to show up
      repeat (2000) @(negedge clk);
      if (received + overruns != good_lines) begin
         errors++;
         $display("Readings %0d plus overruns %0d do not add up to %0d good lines",
                  received, overruns, good_lines);
      end

      $display("Errors: %0d  Overruns: %0d  Readings: %0d", errors, overruns, received);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+include
verilog/ble_reading_pkg.sv
verilog/uart_byte_rx.sv
verilog/hex_line_parser.sv
verilog/hex_digit_decoder.sv
verilog/reading_register.sv
verilog/ble_reading_top.sv
verification/ble_reading_checker.sv
verification/ble_reading_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the reading path testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   -f verilog.f --top-module ble_reading_tb -o ble_reading_sim \
   > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/ble_reading_sim > sim.log 2>&1

grep -qxF '** PASS **' sim.log && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }
